/* verilog/fetch_pkg.sv */
package fetch_pkg;

  // ==================================================
  // widths
  // ==================================================

  localparam int VADDR_W     = 32;
  localparam int INST_W      = 32;
  localparam int FETCH_BYTES = 8;                   // one aligned fetch block
  localparam int BLK_OFS_W   = $clog2(FETCH_BYTES); // byte offset inside a block

  typedef logic [VADDR_W-1:0]       vaddr_t;        // fetch pc and bus address
  typedef logic [INST_W-1:0]        inst_t;
  typedef logic [8*FETCH_BYTES-1:0] fetch_data_t;   // lower word = lower address

  // ==================================================
  // redirects from commit and branch
  // ==================================================

  typedef enum logic [1:0] {
    REDIR_SILENT  = 2'd0,   // restart after the committed inst
    REDIR_REFETCH = 2'd1,   // restart at the committed inst
    REDIR_TRAP    = 2'd2    // restart at the trap vector
  } redirect_kind_e;

  typedef struct packed {
    logic           valid;
    redirect_kind_e kind;
    vaddr_t         epc;
  } commit_redirect_t;

  typedef struct packed {
    logic   valid;
    vaddr_t target;         // mispredict target
  } br_redirect_t;

  // ==================================================
  // fetch data path
  // ==================================================

  // pc is the requested pc, it may point at the upper word
  typedef struct packed {
    vaddr_t      pc;
    fetch_data_t data;
  } fetch_blk_t;

  typedef struct packed {
    vaddr_t pc;
    inst_t  inst;
  } inst_pkt_t;

endpackage

/* verilog/fetch_pc_gen.sv */
module fetch_pc_gen #(
  parameter fetch_pkg::vaddr_t RESET_PC = 32'h0000_1000
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  // redirects
  input  fetch_pkg::commit_redirect_t i_commit,
  input  fetch_pkg::br_redirect_t     i_br,
  input  fetch_pkg::vaddr_t           i_trap_vec,

  // wishbone classic master, read only
  output logic                        o_wb_cyc,
  output logic                        o_wb_stb,
  output fetch_pkg::vaddr_t           o_wb_adr,
  input  fetch_pkg::fetch_data_t      i_wb_dat,
  input  logic                        i_wb_ack,

  // block buffer
  input  logic                        i_buf_full,
  output logic                        o_push,
  output fetch_pkg::fetch_blk_t       o_blk,
  output logic                        o_flush
);

  typedef enum logic [1:0] {
    INIT      = 2'd0,
    FETCH_REQ = 2'd1,   // bus cycle outstanding
    WAIT_BUF  = 2'd2,   // block held, buffer full
    IDLE_GAP  = 2'd3    // bus idle until the buffer has room
  } fetch_state_e;

  fetch_state_e           r_state;
  fetch_state_e           w_state_next;
  fetch_pkg::vaddr_t      r_req_pc;       // pc of the outstanding or held block
  fetch_pkg::vaddr_t      w_req_pc_next;
  fetch_pkg::vaddr_t      r_redir_pc;     // newest restart pc
  logic                   r_stale;        // outstanding block is dead
  logic                   w_stale_next;
  fetch_pkg::fetch_data_t r_hold_data;
  logic                   w_hold;
  fetch_pkg::vaddr_t      w_redir_pc;
  fetch_pkg::vaddr_t      w_blk_base;
  fetch_pkg::vaddr_t      w_seq_pc;

  // ==================================================
  // redirect selection, commit over branch
  // ==================================================

  assign o_flush = i_commit.valid | i_br.valid;

  always_comb begin
    if (i_commit.valid) begin
      case (i_commit.kind)
        fetch_pkg::REDIR_SILENT:  w_redir_pc = i_commit.epc + fetch_pkg::vaddr_t'(4);
        fetch_pkg::REDIR_REFETCH: w_redir_pc = i_commit.epc;
        fetch_pkg::REDIR_TRAP:    w_redir_pc = i_trap_vec;
        default:                  w_redir_pc = i_commit.epc;
      endcase
    end else begin
      w_redir_pc = i_br.target;
    end
  end

  assign w_blk_base = {r_req_pc[fetch_pkg::VADDR_W-1:fetch_pkg::BLK_OFS_W],
                       {fetch_pkg::BLK_OFS_W{1'b0}}};
  assign w_seq_pc   = w_blk_base + fetch_pkg::vaddr_t'(fetch_pkg::FETCH_BYTES);

  // ==================================================
  // fetch FSM
  // ==================================================

  always_comb begin
    w_state_next  = r_state;
    w_req_pc_next = r_req_pc;
    w_stale_next  = r_stale;
    w_hold        = 1'b0;
    o_push        = 1'b0;
    case (r_state)
      INIT: begin
        w_state_next = FETCH_REQ;
        if (o_flush) begin
          w_req_pc_next = w_redir_pc;
        end
      end
      FETCH_REQ: begin
        if (i_wb_ack) begin
          w_stale_next = 1'b0;
          if (o_flush) begin
            w_req_pc_next = w_redir_pc;   // drop block, restart at once
          end else if (r_stale) begin
            w_req_pc_next = r_redir_pc;
          end else if (!i_buf_full) begin
            o_push        = 1'b1;
            w_req_pc_next = w_seq_pc;     // back to back request
          end else begin
            w_hold       = 1'b1;
            w_state_next = WAIT_BUF;
          end
        end else if (o_flush) begin
          w_stale_next = 1'b1;            // adr must hold until ack
        end
      end
      WAIT_BUF: begin
        if (o_flush) begin
          w_req_pc_next = w_redir_pc;
          w_state_next  = FETCH_REQ;
        end else if (!i_buf_full) begin
          o_push        = 1'b1;
          w_req_pc_next = w_seq_pc;
          w_state_next  = IDLE_GAP;
        end
      end
      IDLE_GAP: begin
        if (o_flush) begin
          w_req_pc_next = w_redir_pc;
          w_state_next  = FETCH_REQ;
        end else if (!i_buf_full) begin
          w_state_next = FETCH_REQ;
        end
      end
      default: begin
        w_state_next = INIT;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state  <= INIT;
      r_req_pc <= RESET_PC;
      r_stale  <= 1'b0;
    end else begin
      r_state  <= w_state_next;
      r_req_pc <= w_req_pc_next;
      r_stale  <= w_stale_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_flush) begin
      r_redir_pc <= w_redir_pc;
    end
    if (w_hold) begin
      r_hold_data <= i_wb_dat;
    end
  end

  // ==================================================
  // bus and buffer outputs
  // ==================================================

  assign o_wb_cyc = (r_state == FETCH_REQ);
  assign o_wb_stb = (r_state == FETCH_REQ);
  assign o_wb_adr = w_blk_base;            // block aligned

  assign o_blk = '{pc:   r_req_pc,
                   data: (r_state == WAIT_BUF) ? r_hold_data : i_wb_dat};

endmodule

/* verilog/fetch_inst_buffer.sv */
module fetch_inst_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,

  // write side
  input  logic                  i_push,
  input  fetch_pkg::fetch_blk_t i_blk,
  output logic                  o_full,

  // read side
  input  logic                  i_pop,
  output logic                  o_valid,
  output fetch_pkg::fetch_blk_t o_head
);

  localparam int PTR_W = $clog2(BUF_DEPTH);

  fetch_pkg::fetch_blk_t r_mem [BUF_DEPTH];
  logic [PTR_W-1:0]      r_wr_ptr;
  logic [PTR_W-1:0]      r_rd_ptr;
  logic [PTR_W:0]        r_count;
  logic                  w_do_push;
  logic                  w_do_pop;

  // ==================================================
  // status
  // ==================================================

  assign o_full  = (r_count == (PTR_W+1)'(BUF_DEPTH));
  assign o_valid = (r_count != '0);
  assign o_head  = r_mem[r_rd_ptr];

  // a flush cycle drops whatever arrives with it
  assign w_do_push = i_push & ~o_full & ~i_flush;
  assign w_do_pop  = i_pop & o_valid & ~i_flush;

  // ==================================================
  // pointers and count
  // ==================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_do_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;    // depth is a power of two
      end
      if (w_do_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({w_do_push, w_do_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // storage
  always_ff @(posedge i_clk) begin
    if (w_do_push) begin
      r_mem[r_wr_ptr] <= i_blk;
    end
  end

endmodule

/* verilog/fetch_inst_issue.sv */
module fetch_inst_issue (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_flush,

  // from the block buffer
  input  logic                  i_blk_valid,
  input  fetch_pkg::fetch_blk_t i_head,
  output logic                  o_pop,

  // instruction output
  output logic                  o_inst_valid,
  output fetch_pkg::inst_pkt_t  o_inst,
  input  logic                  i_inst_ready
);

  // pc bit that picks the word inside a block
  localparam int SLOT_BIT = $clog2(fetch_pkg::INST_W / 8);

  logic              r_lo_done;   // lower slot of the head already taken
  logic              w_slot;
  logic              w_accept;
  fetch_pkg::vaddr_t w_blk_base;

  // ==================================================
  // slot select
  // ==================================================

  // redirect into the upper word skips the lower slot
  assign w_slot = i_head.pc[SLOT_BIT] | r_lo_done;

  assign w_blk_base = {i_head.pc[fetch_pkg::VADDR_W-1:fetch_pkg::BLK_OFS_W],
                       {fetch_pkg::BLK_OFS_W{1'b0}}};

  assign o_inst_valid = i_blk_valid & ~i_flush;
  assign o_inst = '{pc:   w_blk_base + (fetch_pkg::vaddr_t'(w_slot) << SLOT_BIT),
                    inst: i_head.data[fetch_pkg::INST_W*w_slot +: fetch_pkg::INST_W]};

  assign w_accept = o_inst_valid & i_inst_ready;
  assign o_pop    = w_accept & w_slot;   // upper word done

  // ==================================================
  // slot state
  // ==================================================

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_lo_done <= 1'b0;
    end else if (i_flush) begin
      r_lo_done <= 1'b0;
    end else if (w_accept) begin
      r_lo_done <= ~w_slot;             // lower taken, or next block
    end
  end

endmodule

/* verilog/fetch_frontend.sv */
module fetch_frontend #(
  parameter fetch_pkg::vaddr_t RESET_PC  = 32'h0000_1000,
  parameter int                BUF_DEPTH = 4
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  // redirects
  input  fetch_pkg::commit_redirect_t i_commit,
  input  fetch_pkg::br_redirect_t     i_br,
  input  fetch_pkg::vaddr_t           i_trap_vec,

  // wishbone master
  output logic                        o_wb_cyc,
  output logic                        o_wb_stb,
  output fetch_pkg::vaddr_t           o_wb_adr,
  input  fetch_pkg::fetch_data_t      i_wb_dat,
  input  logic                        i_wb_ack,

  // instruction stream
  output fetch_pkg::inst_pkt_t        o_inst,
  output logic                        o_inst_valid,
  input  logic                        i_inst_ready
);

  logic                  w_push;
  fetch_pkg::fetch_blk_t w_blk;
  logic                  w_buf_full;
  logic                  w_flush;
  logic                  w_blk_valid;
  fetch_pkg::fetch_blk_t w_head;
  logic                  w_pop;

  // ==================================================
  // producer
  // ==================================================

  fetch_pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_commit   (i_commit),
    .i_br       (i_br),
    .i_trap_vec (i_trap_vec),
    .o_wb_cyc   (o_wb_cyc),
    .o_wb_stb   (o_wb_stb),
    .o_wb_adr   (o_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .i_wb_ack   (i_wb_ack),
    .i_buf_full (w_buf_full),
    .o_push     (w_push),
    .o_blk      (w_blk),
    .o_flush    (w_flush)
  );

  // block FIFO
  fetch_inst_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_inst_buffer (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (w_flush),
    .i_push    (w_push),
    .i_blk     (w_blk),
    .o_full    (w_buf_full),
    .i_pop     (w_pop),
    .o_valid   (w_blk_valid),
    .o_head    (w_head)
  );

  // ==================================================
  // consumer
  // ==================================================

  fetch_inst_issue u_inst_issue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_flush),
    .i_blk_valid  (w_blk_valid),
    .i_head       (w_head),
    .o_pop        (w_pop),
    .o_inst_valid (o_inst_valid),
    .o_inst       (o_inst),
    .i_inst_ready (i_inst_ready)
  );

endmodule

/* verif/fetch_wb_props.sv */
module fetch_wb_props (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  fetch_pkg::vaddr_t    i_wb_adr,
  input  logic                 i_wb_ack,
  input  logic                 i_flush,
  input  logic                 i_inst_valid,
  input  logic                 i_inst_ready,
  input  fetch_pkg::inst_pkt_t i_inst
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;   // assertion failures so far

  // ==================================================
  // wishbone master
  // ==================================================

  a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wb_stb |-> i_wb_cyc)
    else begin
      fail_count++;
      $error("wishbone stb high without cyc");
    end

  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_wb_stb && !i_wb_ack) |=> (i_wb_stb && $stable(i_wb_adr)))
    else begin
      fail_count++;
      $error("wishbone request changed before ack");
    end

  // ==================================================
  // instruction output
  // ==================================================

  a_no_valid_in_flush: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush |-> !i_inst_valid)
    else begin
      fail_count++;
      $error("instruction valid during a flush");
    end

  // a flush may drop a waiting instruction
  a_out_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_inst_valid && !i_inst_ready) |=> (i_flush || (i_inst_valid && $stable(i_inst))))
    else begin
      fail_count++;
      $error("instruction output changed while stalled");
    end

endmodule

/* verif/fetch_checker.sv */
module fetch_checker #(
  parameter fetch_pkg::vaddr_t RESET_PC = 32'h0000_1000
) (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  fetch_pkg::commit_redirect_t i_commit,
  input  fetch_pkg::br_redirect_t     i_br,
  input  fetch_pkg::vaddr_t           i_trap_vec,
  input  logic                        i_inst_valid,
  input  logic                        i_inst_ready,
  input  fetch_pkg::inst_pkt_t        i_inst,
  output int                          o_mismatches,
  output int                          o_protocol_errs,
  output int                          o_accepted
);
  timeunit 1ns;
  timeprecision 100ps;

  fetch_pkg::vaddr_t r_exp_pc;
  fetch_pkg::inst_t  w_exp_inst;

  assign w_exp_inst = r_exp_pc ^ 32'hC0DE_0000;   // memory word rule

  initial begin
    o_mismatches    = 0;
    o_protocol_errs = 0;
    o_accepted      = 0;
  end

  // outputs are sampled at the rising edge, inputs change on the falling one
  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_exp_pc <= RESET_PC;
    end else if (i_commit.valid || i_br.valid) begin
      if (i_inst_valid) begin
        $display("instruction output valid during a flush cycle at %0t", $time);
        o_protocol_errs = o_protocol_errs + 1;
      end
      // newest redirect wins, commit before branch
      if (i_commit.valid) begin
        case (i_commit.kind)
          fetch_pkg::REDIR_SILENT:  r_exp_pc <= i_commit.epc + 32'd4;
          fetch_pkg::REDIR_REFETCH: r_exp_pc <= i_commit.epc;
          default:                  r_exp_pc <= i_trap_vec;
        endcase
      end else begin
        r_exp_pc <= i_br.target;
      end
    end else if (i_inst_valid && i_inst_ready) begin
      if (i_inst.pc !== r_exp_pc) begin
        $display("mismatch o_inst.pc: got %h expected %h at %0t", i_inst.pc, r_exp_pc, $time);
        o_mismatches = o_mismatches + 1;
      end
      if (i_inst.inst !== w_exp_inst) begin
        $display("mismatch o_inst.inst: got %h expected %h at %0t",
                 i_inst.inst, w_exp_inst, $time);
        o_mismatches = o_mismatches + 1;
      end
      o_accepted = o_accepted + 1;
      r_exp_pc <= r_exp_pc + 32'd4;   // next in sequence
    end
  end

endmodule

/* verif/tb_fetch_frontend.sv */
module tb_fetch_frontend;
  timeunit 1ns;
  timeprecision 100ps;

  localparam fetch_pkg::vaddr_t RESET_PC  = 32'h0000_1000;
  localparam int                BUF_DEPTH = 4;
  localparam int                NUM_ROWS  = 12;
  localparam logic [1:0]        RD_NONE   = 2'd0;
  localparam logic [1:0]        RD_COMMIT = 2'd1;   // bit 0 commit, bit 1 branch
  localparam logic [1:0]        RD_BRANCH = 2'd2;
  localparam logic [1:0]        RD_BOTH   = 2'd3;

  typedef struct packed {
    logic [15:0]               cycles;
    logic [1:0]                redir;
    fetch_pkg::redirect_kind_e kind;
    fetch_pkg::vaddr_t         epc;
    fetch_pkg::vaddr_t         target;
    fetch_pkg::vaddr_t         trap_vec;
    logic                      rand_ready;
  } stim_row_t;

  logic                        clk        = 1'b0;
  logic                        reset_n    = 1'b0;
  fetch_pkg::commit_redirect_t commit     = '0;
  fetch_pkg::br_redirect_t     br         = '0;
  fetch_pkg::vaddr_t           trap_vec   = '0;
  fetch_pkg::fetch_data_t      wb_dat     = '0;
  logic                        wb_ack     = 1'b0;
  logic                        inst_ready = 1'b0;
  logic                        wb_cyc;
  logic                        wb_stb;
  fetch_pkg::vaddr_t           wb_adr;
  fetch_pkg::inst_pkt_t        inst;
  logic                        inst_valid;
  integer                      seed       = 32'h8175;
  stim_row_t                   rows [NUM_ROWS];
  int                          mismatches;
  int                          protocol_errs;
  int                          accepted;
  int                          assert_errs = 0;
  int                          other_errs = 0;
  logic                        mem_busy   = 1'b0;
  int unsigned                 mem_wait   = 0;

  always #5 clk = ~clk;

  fetch_frontend #(
    .RESET_PC  (RESET_PC),
    .BUF_DEPTH (BUF_DEPTH)
  ) uut (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_commit (commit), .i_br (br), .i_trap_vec (trap_vec),
    .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_adr (wb_adr),
    .i_wb_dat (wb_dat), .i_wb_ack (wb_ack),
    .o_inst (inst), .o_inst_valid (inst_valid), .i_inst_ready (inst_ready)
  );

  fetch_checker #(
    .RESET_PC (RESET_PC)
  ) u_checker (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_commit (commit), .i_br (br), .i_trap_vec (trap_vec),
    .i_inst_valid (inst_valid), .i_inst_ready (inst_ready), .i_inst (inst),
    .o_mismatches (mismatches), .o_protocol_errs (protocol_errs), .o_accepted (accepted)
  );

  // flush cycle seen from the redirect ports
  bind fetch_frontend fetch_wb_props u_wb_props (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_wb_cyc (o_wb_cyc), .i_wb_stb (o_wb_stb), .i_wb_adr (o_wb_adr), .i_wb_ack (i_wb_ack),
    .i_flush (i_commit.valid | i_br.valid),
    .i_inst_valid (o_inst_valid), .i_inst_ready (i_inst_ready),
    .i_inst (o_inst)
  );

  // ==================================================
  // wishbone memory model
  // ==================================================

  function automatic fetch_pkg::fetch_data_t mem_block(input fetch_pkg::vaddr_t adr);
    return {(adr + 32'd4) ^ 32'hC0DE_0000, adr ^ 32'hC0DE_0000};
  endfunction

  always @(negedge clk) begin
    if (!reset_n) begin
      wb_ack   = 1'b0;
      mem_busy = 1'b0;
    end else begin
      if (wb_ack) begin
        wb_ack   = 1'b0;   // single cycle ack
        mem_busy = 1'b0;
      end
      if (wb_cyc && wb_stb && !mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = $unsigned($random(seed)) % 4;
      end
      if (mem_busy) begin
        if (mem_wait == 0) begin
          wb_ack = 1'b1;
          wb_dat = mem_block(wb_adr);
        end else begin
          mem_wait = mem_wait - 1;
        end
      end
    end
  end

  // ==================================================
  // stimulus table
  // ==================================================

  function automatic stim_row_t make_row(input int cycles, input logic [1:0] redir,
                                         input fetch_pkg::redirect_kind_e kind,
                                         input fetch_pkg::vaddr_t epc,
                                         input fetch_pkg::vaddr_t target,
                                         input fetch_pkg::vaddr_t tvec, input logic rnd);
    return '{cycles[15:0], redir, kind, epc, target, tvec, rnd};
  endfunction

  task automatic fill_table();
    rows[0]  = make_row(60,  RD_NONE,   fetch_pkg::REDIR_SILENT,  '0, '0, 32'h800, 1'b0);
    rows[1]  = make_row(120, RD_NONE,   fetch_pkg::REDIR_SILENT,  '0, '0, 32'h800, 1'b1);
    rows[2]  = make_row(40,  RD_BRANCH, fetch_pkg::REDIR_SILENT,  '0, 32'h2004, 32'h800, 1'b0);
    rows[3]  = make_row(40,  RD_COMMIT, fetch_pkg::REDIR_SILENT,  32'h3000, '0, 32'h800, 1'b1);
    rows[4]  = make_row(40,  RD_COMMIT, fetch_pkg::REDIR_REFETCH, 32'h3100, '0, 32'h800, 1'b0);
    rows[5]  = make_row(40,  RD_COMMIT, fetch_pkg::REDIR_TRAP,    32'h3200, '0, 32'h800, 1'b1);
    rows[6]  = make_row(3,   RD_BRANCH, fetch_pkg::REDIR_SILENT,  '0, 32'h4000, 32'h800, 1'b0);
    rows[7]  = make_row(40,  RD_COMMIT, fetch_pkg::REDIR_REFETCH, 32'h5008, '0, 32'h800, 1'b0);
    rows[8]  = make_row(40,  RD_BOTH,   fetch_pkg::REDIR_SILENT,  32'h6000, 32'h7000, 32'h800, 1'b1);
    rows[9]  = make_row(2,   RD_BRANCH, fetch_pkg::REDIR_SILENT,  '0, 32'h7004, 32'h900, 1'b0);
    rows[10] = make_row(50,  RD_COMMIT, fetch_pkg::REDIR_TRAP,    32'h7010, '0, 32'h900, 1'b1);
    rows[11] = make_row(60,  RD_NONE,   fetch_pkg::REDIR_SILENT,  '0, '0, 32'h900, 1'b1);
  endtask

  // redirect only in the first cycle of a row
  task automatic apply_row(input stim_row_t row);
    for (int c = 0; c < row.cycles; c++) begin
      commit = '0;
      br     = '0;
      if (c == 0) begin
        commit.valid = row.redir[0];
        commit.kind  = row.kind;
        commit.epc   = row.epc;
        br.valid     = row.redir[1];
        br.target    = row.target;
      end
      trap_vec   = row.trap_vec;
      inst_ready = row.rand_ready ? 1'($random(seed)) : 1'b1;
      @(negedge clk);
    end
  endtask

  task automatic watchdog(input int cycles);
    #(cycles * 10);
    $display("timeout: run did not finish within %0d cycles", cycles);
    $display("Test failed");
    $finish;
  endtask

  initial begin
    int limit;
    int acc_before;
    fill_table();
    limit = 200;
    for (int i = 0; i < NUM_ROWS; i++) begin
      limit += rows[i].cycles;
    end
    fork
      watchdog(limit);
    join_none
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      acc_before = accepted;
      apply_row(rows[i]);
      if (rows[i].cycles >= 40 && accepted == acc_before) begin
        $display("no instruction was accepted during row %0d", i);
        other_errs++;
      end
    end
    assert_errs = uut.u_wb_props.fail_count;
    $display("errors: mismatch %0d, protocol %0d, assertion %0d, other %0d (%0d accepted)",
             mismatches, protocol_errs, assert_errs, other_errs, accepted);
    if (mismatches + protocol_errs + assert_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* src.f */
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_inst_buffer.sv
verilog/fetch_inst_issue.sv
verilog/fetch_frontend.sv
verif/fetch_wb_props.sv
verif/fetch_checker.sv
verif/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_pc_gen.sv
      - verilog/fetch_inst_buffer.sv
      - verilog/fetch_inst_issue.sv
      - verilog/fetch_frontend.sv
  - target: test
    files:
      - verif/fetch_wb_props.sv
      - verif/fetch_checker.sv
      - verif/tb_fetch_frontend.sv
